// File: pce_pad_pkg.sv
// Console joypad port types and constants

`default_nettype none

package pce_pad_pkg;

	// ==========================================================
	// Pad words
	// ==========================================================

	// Raw host pad in host order
	// [3:0] right, left, down, up
	// [7:4] I, II, select, run
	// [11:8] III to VI
	typedef logic [11:0] pad_raw_t;

	typedef logic [15:0] pad_word_t; // Active-low console word for one port
	typedef logic [3:0]  nibble_t;   // Console data lines
	typedef logic [2:0]  port_idx_t; // Multitap port number

	// ==========================================================
	// Mouse readout
	// ==========================================================

	// One nibble per CLR sequence, X then Y, high half first
	typedef enum logic [1:0] {
		MS_X_HI,
		MS_X_LO,
		MS_Y_HI,
		MS_Y_LO
	} mouse_phase_e;

	// ==========================================================
	// Constants
	// ==========================================================

	// Returned for a port beyond the last pad
	localparam pad_word_t UNUSED_PORT_WORD = 16'h0FFF;

	localparam int DEFAULT_NUM_PORTS     = 5;  // Five-port multitap
	localparam int DEFAULT_MOUSE_TO_BITS = 15; // Idle timeout counter width

endpackage

`default_nettype wire

// File: pad_mapper.sv
// Host pad swap and remap
// Builds the console word of every multitap port

`timescale 1ns/1ns
`default_nettype none

module pad_mapper import pce_pad_pkg::*; #(
	parameter int NUM_PORTS = DEFAULT_NUM_PORTS
) (
	input  pad_raw_t                  pad_a,
	input  pad_raw_t                  pad_b,
	input  pad_raw_t                  pad_2,
	input  pad_raw_t                  pad_3,
	input  pad_raw_t                  pad_4,
	input  logic                      joy_swap,
	input  logic                      mouse_en,
	input  logic [1:0]                mouse_btn,
	input  nibble_t                   motion_nibble,
	output pad_word_t [NUM_PORTS-1:0] port_words
);

	localparam int HOST_PADS = 5;

	pad_raw_t   host_pad [HOST_PADS];
	logic [7:0] mouse_byte;

	// Host buttons to the active-low console layout
	function automatic pad_word_t remap_pad(input pad_raw_t raw);
		return {4'h0, ~raw[11:8], ~raw[1], ~raw[2], ~raw[0], ~raw[3], ~raw[7:4]};
	endfunction

	// First two pads trade places on swap
	assign host_pad[0] = joy_swap ? pad_b : pad_a;
	assign host_pad[1] = joy_swap ? pad_a : pad_b;
	assign host_pad[2] = pad_2;
	assign host_pad[3] = pad_3;
	assign host_pad[4] = pad_4;

	// Motion on top, run/select and mouse buttons below
	assign mouse_byte = {motion_nibble, ~{host_pad[0][7:6], mouse_btn[0], mouse_btn[1]}};

	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
		if (p == 0) begin : g_first
			assign port_words[p] = mouse_en ? {mouse_byte, mouse_byte} : remap_pad(host_pad[0]);
		end else if (p < HOST_PADS) begin : g_pad
			assign port_words[p] = remap_pad(host_pad[p]);
		end else begin : g_none
			assign port_words[p] = UNUSED_PORT_WORD; // No host pad behind this port
		end
	end

endmodule

`default_nettype wire

// File: mouse_tracker.sv
// Mouse motion accumulator
// Serves motion as one nibble per CLR sequence

`timescale 1ns/1ns
`default_nettype none

module mouse_tracker import pce_pad_pkg::*; #(
	parameter int MOUSE_TO_BITS = DEFAULT_MOUSE_TO_BITS
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       mouse_strobe,
	input  logic       joy_clr,
	input  logic       clr_rise,
	input  logic [7:0] mouse_x,
	input  logic [7:0] mouse_y,
	output nibble_t    motion_nibble
);

	logic [7:0]               acc_x;
	logic [7:0]               acc_y;
	logic [7:0]               snap_x;
	logic [7:0]               snap_y;
	mouse_phase_e             phase;
	logic [MOUSE_TO_BITS-1:0] idle_cnt;
	logic                     idle_sat;
	logic                     frame_end;

	assign idle_sat  = &idle_cnt;
	assign frame_end = clr_rise && (phase == MS_Y_LO); // Last nibble of a readout done

	// ==========================================================
	// Idle timeout
	// ==========================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			idle_cnt <= '0;
		end else if (joy_clr) begin
			idle_cnt <= '0;
		end else if (!idle_sat) begin
			idle_cnt <= idle_cnt + 1'b1;
		end
	end

	// Phase steps on every CLR rise
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			phase <= MS_Y_LO;
		end else if (clr_rise) begin
			phase <= mouse_phase_e'(phase + 2'd1);
		end else if (idle_sat) begin
			phase <= MS_Y_LO; // Host stopped polling, resync
		end
	end

	// ==========================================================
	// Accumulators and snapshots
	// ==========================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc_x  <= '0;
			acc_y  <= '0;
			snap_x <= '0;
			snap_y <= '0;
		end else begin
			if (frame_end) begin
				snap_x <= acc_x;
				snap_y <= acc_y;
				acc_x  <= '0;
				acc_y  <= '0;
			end
			if (mouse_strobe) begin
				acc_x <= 8'd0 - mouse_x; // Console X runs the other way
				acc_y <= mouse_y;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			motion_nibble <= '0;
		end else begin
			unique case (phase)
				MS_X_HI: motion_nibble <= snap_x[7:4];
				MS_X_LO: motion_nibble <= snap_x[3:0];
				MS_Y_HI: motion_nibble <= snap_y[7:4];
				MS_Y_LO: motion_nibble <= snap_y[3:0];
			endcase
		end
	end

endmodule

`default_nettype wire

// File: port_scanner.sv
// SEL/CLR edge detect, multitap port and button page

`timescale 1ns/1ns
`default_nettype none

module port_scanner import pce_pad_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      joy_sel,
	input  logic      joy_clr,
	input  logic      turbotap,
	input  logic      buttons6,
	output port_idx_t port_idx,
	output logic      high_page,
	output logic      clr_rise
);

	logic sel_s;
	logic clr_s;
	logic sel_d;
	logic clr_d;
	logic sel_edge;
	logic clr_edge;

	// Sampled console lines and their previous values
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sel_s <= 1'b0;
			clr_s <= 1'b0;
			sel_d <= 1'b0;
			clr_d <= 1'b0;
		end else begin
			sel_s <= joy_sel;
			clr_s <= joy_clr;
			sel_d <= sel_s;
			clr_d <= clr_s;
		end
	end

	assign sel_edge = sel_s & ~sel_d;
	assign clr_edge = clr_s & ~clr_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clr_rise  <= 1'b0;
			high_page <= 1'b0;
			port_idx  <= '0;
		end else begin
			clr_rise <= clr_edge;
			if (clr_edge) begin
				high_page <= buttons6 & ~high_page; // Two-button pads stay on page 0
			end
			if (clr_s) begin
				port_idx <= '0;
			end else if (sel_edge && turbotap && port_idx != 3'd7) begin
				port_idx <= port_idx + 3'd1; // Next multitap port
			end
		end
	end

endmodule

`default_nettype wire

// File: nibble_latch.sv
// Console data nibble select and register

`timescale 1ns/1ns
`default_nettype none

module nibble_latch import pce_pad_pkg::*; #(
	parameter int NUM_PORTS = DEFAULT_NUM_PORTS
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      joy_sel,
	input  logic                      joy_clr,
	input  logic                      high_page,
	input  port_idx_t                 port_idx,
	input  pad_word_t [NUM_PORTS-1:0] port_words,
	output nibble_t                   joy_in
);

	pad_word_t word_sel;
	nibble_t   nibble_sel;

	always_comb begin
		word_sel = UNUSED_PORT_WORD; // Past the last port
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (port_idx == port_idx_t'(i)) begin
				word_sel = port_words[i];
			end
		end
	end

	// Nibble 2*page + SEL of the current word
	assign nibble_sel = word_sel[{high_page, joy_sel, 2'b00} +: 4];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			joy_in <= '0;
		end else if (joy_clr) begin
			joy_in <= '0;
		end else begin
			joy_in <= nibble_sel;
		end
	end

endmodule

`default_nettype wire

// File: pce_pad_top.sv
// Console joypad port controller

`timescale 1ns/1ns
`default_nettype none

module pce_pad_top import pce_pad_pkg::*; #(
	parameter int NUM_PORTS     = DEFAULT_NUM_PORTS,
	parameter int MOUSE_TO_BITS = DEFAULT_MOUSE_TO_BITS
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  pad_raw_t   pad_a,
	input  pad_raw_t   pad_b,
	input  pad_raw_t   pad_2,
	input  pad_raw_t   pad_3,
	input  pad_raw_t   pad_4,
	input  logic       joy_swap,
	input  logic       turbotap,
	input  logic       buttons6,
	input  logic       mouse_en,
	input  logic [7:0] mouse_x,
	input  logic [7:0] mouse_y,
	input  logic       mouse_strobe,
	input  logic [1:0] mouse_btn,   // Left, right
	input  logic       joy_sel,
	input  logic       joy_clr,
	output nibble_t    joy_in
);

	pad_word_t [NUM_PORTS-1:0] port_words;
	nibble_t                   motion_nibble;
	port_idx_t                 port_idx;
	logic                      high_page;
	logic                      clr_rise;

	// ==========================================================
	// Input side
	// ==========================================================

	pad_mapper #(
		.NUM_PORTS(NUM_PORTS)
	) u_pad_mapper (
		.pad_a(pad_a),
		.pad_b(pad_b),
		.pad_2(pad_2),
		.pad_3(pad_3),
		.pad_4(pad_4),
		.joy_swap(joy_swap),
		.mouse_en(mouse_en),
		.mouse_btn(mouse_btn),
		.motion_nibble(motion_nibble),
		.port_words(port_words)
	);

	mouse_tracker #(
		.MOUSE_TO_BITS(MOUSE_TO_BITS)
	) u_mouse_tracker (
		.clk_sys(clk_sys),
		.reset(reset),
		.mouse_strobe(mouse_strobe),
		.joy_clr(joy_clr),
		.clr_rise(clr_rise),
		.mouse_x(mouse_x),
		.mouse_y(mouse_y),
		.motion_nibble(motion_nibble)
	);

	// ==========================================================
	// Port scan and output
	// ==========================================================

	port_scanner u_port_scanner (
		.clk_sys(clk_sys),
		.reset(reset),
		.joy_sel(joy_sel),
		.joy_clr(joy_clr),
		.turbotap(turbotap),
		.buttons6(buttons6),
		.port_idx(port_idx),
		.high_page(high_page),
		.clr_rise(clr_rise)
	);

	nibble_latch #(
		.NUM_PORTS(NUM_PORTS)
	) u_nibble_latch (
		.clk_sys(clk_sys),
		.reset(reset),
		.joy_sel(joy_sel),
		.joy_clr(joy_clr),
		.high_page(high_page),
		.port_idx(port_idx),
		.port_words(port_words),
		.joy_in(joy_in)
	);

endmodule

`default_nettype wire

// File: pce_pad_checker.sv
// Joypad port rule assertions

`timescale 1ns/1ns
`default_nettype none

module pce_pad_checker import pce_pad_pkg::*; (
	input logic      clk_sys,
	input logic      reset,
	input logic      joy_clr,
	input logic      turbotap,
	input nibble_t   joy_in,
	input port_idx_t port_idx
);

	// Output cleared by reset
	a_reset_zero: assert property (@(posedge clk_sys) reset |=> joy_in == 4'h0)
		else $error("joy_in not 0 after reset");

	a_clr_zero: assert property (@(posedge clk_sys) disable iff (reset)
		joy_clr |=> joy_in == 4'h0)
		else $error("joy_in not 0 after CLR high");

	// No multitap scan without turbotap
	a_port_hold: assert property (@(posedge clk_sys) disable iff (reset)
		(!turbotap && port_idx == 3'd0) |=> port_idx == 3'd0)
		else $error("port_idx moved with turbotap low");

endmodule

bind pce_pad_top pce_pad_checker u_checker (
	.clk_sys(clk_sys),
	.reset(reset),
	.joy_clr(joy_clr),
	.turbotap(turbotap),
	.joy_in(joy_in),
	.port_idx(port_idx)
);

`default_nettype wire

// File: tb_pce_pad.sv
// Console joypad port testbench

`timescale 1ns/1ns
`default_nettype none

module tb_pce_pad import pce_pad_pkg::*; ();

	localparam int NUM_PORTS = DEFAULT_NUM_PORTS;

	logic       clk_sys = 1'b0;
	logic       reset;
	pad_raw_t   pad_a, pad_b, pad_2, pad_3, pad_4;
	logic       joy_swap, turbotap, buttons6, mouse_en;
	logic [7:0] mouse_x, mouse_y;
	logic       mouse_strobe;
	logic [1:0] mouse_btn;
	logic       joy_sel, joy_clr;
	nibble_t    joy_in;

	logic [31:0] rng = 32'h06bf3661;
	logic [14:0] steps[$]; // {hold, strobe, men, b6, tap, swap, clr, sel}
	int          errors = 0;
	int          checks = 0;

	pce_pad_top #(.NUM_PORTS(NUM_PORTS), .MOUSE_TO_BITS(6)) dut (.*);

	always #20 clk_sys = ~clk_sys;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Console word of one pad built bit by bit
	function automatic pad_word_t expect_word(input pad_raw_t r);
		pad_word_t w;
		w = 16'h0000;
		w[11:8] = ~r[11:8];
		w[7] = ~r[1];
		w[6] = ~r[2];
		w[5] = ~r[0];
		w[4] = ~r[3];
		w[3:0] = ~r[7:4];
		return w;
	endfunction

	task automatic add_step(input logic sel, clr, swap, tap, b6, men, strobe,
			input logic [7:0] hold);
		steps.push_back({hold, strobe, men, b6, tap, swap, clr, sel});
	endtask

	task automatic check_nibble(input nibble_t got, input nibble_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s nibble got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_port(input port_idx_t got, input port_idx_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s port got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	// ==========================================================
	// Watchdog
	// ==========================================================

	initial begin
		for (int c = 0; c < 20000; c++) begin
			@(posedge clk_sys);
		end
		$display("Simulation ran past its cycle limit");
		$display("*** TEST FAILED ***");
		$finish;
	end

	// ==========================================================
	// Stimulus and reference model
	// ==========================================================

	initial begin
		pad_raw_t   pads[5];
		logic [7:0] acc_x, acc_y, snap_x, snap_y;
		logic [1:0] m_phase;
		port_idx_t  m_port;
		logic       m_page, p_sel, p_clr;
		int         idle;
		logic [14:0] s;
		pad_raw_t   h0, h1;
		pad_word_t  word;
		logic [7:0] mbyte;
		nibble_t    motion, exp;

		reset = 1'b1;
		joy_swap = 0;
		turbotap = 0;
		buttons6 = 0;
		mouse_en = 0;
		mouse_x = 0;
		mouse_y = 0;
		mouse_strobe = 0;
		joy_sel = 0;
		joy_clr = 0;
		for (int i = 0; i < 5; i++) begin
			rng = xorshift(rng);
			pads[i] = rng[11:0];
		end
		mouse_btn = 2'b01;
		{pad_a, pad_b, pad_2, pad_3, pad_4} = {pads[0], pads[1], pads[2], pads[3], pads[4]};

		// Single pad with swap off then on
		add_step(0, 0, 0, 0, 0, 0, 0, 4);
		add_step(1, 0, 0, 0, 0, 0, 0, 4);
		add_step(0, 0, 1, 0, 0, 0, 0, 4);
		add_step(1, 0, 1, 0, 0, 0, 0, 4);
		// Multitap scan past the last port
		add_step(0, 1, 0, 1, 0, 0, 0, 4);
		add_step(0, 0, 0, 1, 0, 0, 0, 4);
		for (int k = 0; k < 6; k++) begin
			add_step(1, 0, 0, 1, 0, 0, 0, 4);
			add_step(0, 0, 0, 1, 0, 0, 0, 4);
		end
		add_step(0, 1, 0, 1, 0, 0, 0, 4);
		add_step(0, 1, 0, 0, 0, 0, 0, 4);
		// Six-button pages
		for (int k = 0; k < 4; k++) begin
			add_step(1, 1, 0, 0, 1, 0, 0, 4);
			add_step(1, 0, 0, 0, 1, 0, 0, 4);
			add_step(0, 0, 0, 0, 1, 0, 0, 4);
		end
		// Mouse readout from a known phase after idle
		add_step(0, 0, 0, 0, 0, 1, 0, 80);
		add_step(0, 0, 0, 0, 0, 1, 1, 4);
		for (int k = 0; k < 8; k++) begin
			add_step(0, 1, 0, 0, 0, 1, 0, 4);
			add_step(1, 0, 0, 0, 0, 1, 0, 4);
			add_step(0, 0, 0, 0, 0, 1, 0, 4);
		end
		// Mouse timeout mid readout
		add_step(0, 0, 0, 0, 0, 1, 1, 4);
		add_step(0, 1, 0, 0, 0, 1, 0, 4);
		add_step(1, 0, 0, 0, 0, 1, 1, 80);
		add_step(0, 1, 0, 0, 0, 1, 0, 4);
		add_step(1, 0, 0, 0, 0, 1, 0, 4);
		add_step(0, 0, 0, 0, 0, 1, 0, 4);

		for (int c = 0; c < 16; c++) begin
			@(posedge clk_sys);
		end
		reset <= 1'b0;
		@(negedge clk_sys);
		check_nibble(joy_in, 4'h0, "after reset");

		acc_x = 0;
		acc_y = 0;
		snap_x = 0;
		snap_y = 0;
		m_phase = 2'd3;
		m_port = 0;
		m_page = 0;
		p_sel = 0;
		p_clr = 0;
		idle = 0;

		foreach (steps[r]) begin
			s = steps[r];
			@(posedge clk_sys);
			joy_sel <= s[0];
			joy_clr <= s[1];
			joy_swap <= s[2];
			turbotap <= s[3];
			buttons6 <= s[4];
			mouse_en <= s[5];
			if (s[6]) begin
				rng = xorshift(rng);
				mouse_x <= rng[7:0];
				mouse_y <= rng[15:8];
				mouse_btn <= ~mouse_btn; // Both button orders get read
				mouse_strobe <= 1'b1;
				acc_x = 8'd0 - rng[7:0]; // Console X is negated
				acc_y = rng[15:8];
			end
			for (int c = 0; c < s[14:7]; c++) begin
				@(posedge clk_sys);
				mouse_strobe <= 1'b0;
			end

			if (s[1] && !p_clr) begin
				m_page = s[4] ? !m_page : 1'b0;
				if (m_phase == 2'd3) begin
					snap_x = acc_x;
					snap_y = acc_y;
					acc_x = 0;
					acc_y = 0;
				end
				m_phase = m_phase + 2'd1;
			end
			if (s[1]) begin
				m_port = 0;
				idle = 0;
			end else begin
				if (s[0] && !p_sel && s[3] && m_port != 3'd7)
					m_port = m_port + 3'd1;
				idle += s[14:7];
				if (idle >= 64)
					m_phase = 2'd3; // Idle timeout resync
			end
			p_sel = s[0];
			p_clr = s[1];

			case (m_phase)
				2'd0: motion = snap_x[7:4];
				2'd1: motion = snap_x[3:0];
				2'd2: motion = snap_y[7:4];
				default: motion = snap_y[3:0];
			endcase
			h0 = s[2] ? pads[1] : pads[0];
			h1 = s[2] ? pads[0] : pads[1];
			mbyte = {motion, ~h0[7], ~h0[6], ~mouse_btn[0], ~mouse_btn[1]};
			if (m_port >= NUM_PORTS) word = 16'h0FFF;
			else if (m_port == 0) word = s[5] ? {mbyte, mbyte} : expect_word(h0);
			else if (m_port == 1) word = expect_word(h1);
			else word = expect_word(pads[m_port]);
			exp = s[1] ? 4'h0 : nibble_t'(word >> (4 * (2 * m_page + s[0])));

			@(negedge clk_sys);
			check_nibble(joy_in, exp, "row");
			check_port(dut.port_idx, m_port, "row");
			$display("row %0d sel=%0b clr=%0b port=%0d joy_in=%h expected %h", r, s[0], s[1],
				m_port, joy_in, exp);
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
pce_pad_pkg.sv
pad_mapper.sv
mouse_tracker.sv
port_scanner.sv
nibble_latch.sv
pce_pad_top.sv
pce_pad_checker.sv
tb_pce_pad.sv

// File: Makefile
# Verilator build for the joypad port testbench

VERILATOR ?= verilator
TOP       ?= tb_pce_pad
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
